//--- src.f
+incdir+.
types.sv
decode.sv
program_counter.sv
instr_sequencer.sv
cpu_frontend.sv
tb_cpu_frontend.sv

//--- tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Register and stack group, upper byte 0xE
function automatic int model_e_group(input logic [7:0] b);
    logic [3:0] hi;
    logic [3:0] lo;
    hi = b[7:4];
    lo = b[3:0];
    if (hi <= 4'h3) return 35;                    // LD r, i
    if (hi <= 4'h5) return 36;                    // PSET
    if (hi == 4'h6) return 37;
    if (hi == 4'h7) return 38;
    if (hi == 4'h8) return 39 + lo[3:2];          // Four ops, no hole
    if (hi <= 4'hB && lo[3:2] != 2'b11) begin
        return 43 + (hi - 9) * 3 + lo[3:2];       // Three ops per row
    end
    if (hi == 4'hC) return 52;
    if (hi == 4'hE) return 53;
    if (hi == 4'hF) return 54;
    return 0;
endfunction

// Memory, stack and misc group, upper nibble 0xF
function automatic int model_f_group(input logic [3:0] n, input logic [3:0] l);
    if (n <= 4'h1) return 55 + n;
    if (n <= 4'h3) begin
        if (l[3:2] < 2'b10) return 0;
        return 57 + (n - 2) * 2 + (l[3:2] - 2);
    end
    if (n <= 4'hB) return 57 + n;                 // One entry per row
    if (l <= 4'h3) begin
        case (n)
            4'hC:    return 69;
            4'hD:    return 78;
            4'hE:    return 89;
            default: return 92;
        endcase
    end
    if (n == 4'hC) return (l <= 4'hB) ? 66 + l : 0;
    if (n == 4'hD) begin
        if (l <= 4'hB) return 75 + l;
        if (l == 4'hE) return 87;                 // RETS
        if (l == 4'hF) return 88;                 // RET
        return 0;
    end
    if (l <= 4'h7) return (n == 4'hE) ? 90 : 93;
    if (n == 4'hE) return (l == 4'h8) ? 91 : 0;
    case (l)
        4'h8:    return 94;
        4'h9:    return 95;
        4'hB:    return 96;
        4'hF:    return 97;
        default: return 0;
    endcase
endfunction

function automatic int model_start_addr(input logic [11:0] op);
    logic [3:0] grp;
    grp = op[11:8];
    if (grp <= 4'h9) return grp;                  // Entry equals group
    if (grp == 4'hA) return 10 + op[7:4];
    if (grp == 4'hB) return 26;
    if (grp == 4'hC) return 27 + op[7:6];
    if (grp == 4'hD) return 31 + op[7:6];
    if (grp == 4'hE) return model_e_group(op[7:0]);
    return model_f_group(op[7:4], op[3:0]);
endfunction

function automatic int model_cycles(input logic [11:0] op);
    int addr;
    addr = model_start_addr(op);
    case (addr)
        1, 87:         return 12;                 // RETD, RETS
        4, 5, 88, 97:  return 7;
        default: begin
            if ((addr >= 10 && addr <= 25) || (addr >= 27 && addr <= 34)) return 7;
            if (addr >= 55 && addr <= 64) return 7;
            return 5;
        end
    endcase
endfunction

function automatic bit model_skip(input logic [11:0] op);
    int addr;
    addr = model_start_addr(op);
    return (addr == 1 || addr == 4 || addr == 5 || addr == 88);  // PC set by execution
endfunction

`endif

//--- tb_cpu_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_frontend;

    `include "tb_decode_model.svh"

    logic              clk;
    logic              reset;
    logic [11:0]       rom_addr;
    logic [11:0]       rom_data;
    logic              pc_load;
    logic [11:0]       pc_load_value;
    types::micro_op_t  uop;
    logic              instr_done;

    logic [11:0] rom [0:4095];
    logic [31:0] lfsr;
    logic [11:0] model_pc;

    cpu_frontend u_cpu_frontend (
        .clk           (clk),
        .reset         (reset),
        .rom_addr      (rom_addr),
        .rom_data      (rom_data),
        .pc_load       (pc_load),
        .pc_load_value (pc_load_value),
        .uop           (uop),
        .instr_done    (instr_done)
    );

    assign rom_data = rom[rom_addr];  // Same-cycle memory answer

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                                        $time, name, actual, expected));
        end
    endtask

    task automatic fill_program_memory();
        logic [3:0] sel;
        logic [7:0] operand;
        for (int a = 0; a < 4096; a++) begin
            sel = rand_bits(4);
            case (sel)
                4'd0: begin
                    operand = rand_bits(8);
                    rom[a]  = {4'h1, operand};  // RETD
                end
                4'd1: begin
                    operand = rand_bits(8);
                    rom[a]  = {4'h4, operand};  // CALL
                end
                4'd2:    rom[a] = 12'hFDF;      // RET
                4'd3:    rom[a] = 12'hFDE;      // RETS
                default: rom[a] = rand_bits(12);
            endcase
        end
    endtask

    task automatic drive_inputs();
        pc_load       = (rand_bits(3) == 3'd0);
        pc_load_value = rand_bits(12);
    endtask

    // Entered on the falling edge of a fetch cycle
    task automatic run_instruction();
        logic [11:0] op;
        int          exp_addr;
        int          exp_cycles;
        bit          exp_skip;
        bit          pending;
        logic [11:0] target;
        int          count;
        bit          finished;
        check_value("rom_addr", rom_addr, model_pc);
        check_value("instr_done", instr_done, 1'b0);
        check_value("uop.first", uop.first, 1'b0);
        op         = rom[model_pc];
        exp_addr   = model_start_addr(op);
        exp_cycles = model_cycles(op);
        exp_skip   = model_skip(op);
        pending    = 1'b0;
        target     = '0;
        drive_inputs();  // Ignored while fetching
        count = 0;
        do begin
            @(negedge clk);
            count++;
            if (!uop.first) begin
                if (count >= 4) stop_with_failure("Execute step 0 never started after fetch");
                drive_inputs();
            end
        end while (!uop.first);
        count    = 0;
        finished = 1'b0;
        while (!finished) begin
            check_value("uop.step", uop.step, count);
            check_value("uop.first", uop.first, count == 0);
            check_value("uop.start_addr", uop.start_addr, exp_addr);
            check_value("uop.immed", uop.immed, op[7:0]);
            finished = instr_done;
            drive_inputs();
            if (exp_skip && pc_load) begin
                pending = 1'b1;
                target  = pc_load_value;  // Last request wins
            end
            count++;
            if (!finished) begin
                if (count >= 16) stop_with_failure("Timed out waiting for instr_done");
                @(negedge clk);
            end
        end
        check_value("instruction cycles", count, exp_cycles);
        if (!exp_skip) begin
            model_pc = {model_pc[11:8], model_pc[7:0] + 8'd1};  // Wraps in page
        end else if (pending) begin
            model_pc = target;
        end
        @(negedge clk);
    endtask

    initial begin
        reset         = 1'b1;
        pc_load       = 1'b0;
        pc_load_value = '0;
        lfsr          = 32'h086ea55c;
        model_pc      = '0;
        fill_program_memory();
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("instr_done", instr_done, 1'b0);
        check_value("uop.first", uop.first, 1'b0);
        reset = 1'b0;
        check_value("rom_addr", rom_addr, 12'h000);
        for (int n = 0; n < 2000; n++) begin
            run_instruction();
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_frontend (
    input  wire                        clk,
    input  wire                        reset,
    output logic [types::OPCODE_W-1:0] rom_addr,
    input  wire  [types::OPCODE_W-1:0] rom_data,
    input  wire                        pc_load,
    input  wire  [types::OPCODE_W-1:0] pc_load_value,
    output types::micro_op_t           uop,
    output logic                       instr_done
);

    logic [types::OPCODE_W-1:0] opcode;
    types::decode_t             dec;
    logic                       pc_inc;
    logic                       pc_load_en;
    logic [types::OPCODE_W-1:0] pc_next_value;

    program_counter u_program_counter (
        .clk        (clk),
        .reset      (reset),
        .inc        (pc_inc),
        .load_en    (pc_load_en),
        .load_value (pc_next_value),
        .pc         (rom_addr)  // Registered PC drives memory directly
    );

    instr_sequencer u_instr_sequencer (
        .clk           (clk),
        .reset         (reset),
        .rom_data      (rom_data),
        .dec           (dec),
        .pc_load       (pc_load),
        .pc_load_value (pc_load_value),
        .opcode        (opcode),
        .pc_inc        (pc_inc),
        .pc_load_en    (pc_load_en),
        .pc_next_value (pc_next_value),
        .uop           (uop),
        .instr_done    (instr_done)
    );

    decode u_decode (
        .opcode (opcode),
        .dec    (dec)
    );

endmodule

`default_nettype wire

//--- instr_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module instr_sequencer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire  [types::OPCODE_W-1:0] rom_data,
    input  types::decode_t             dec,
    input  wire                        pc_load,
    input  wire  [types::OPCODE_W-1:0] pc_load_value,
    output logic [types::OPCODE_W-1:0] opcode,
    output logic                       pc_inc,
    output logic                       pc_load_en,
    output logic [types::OPCODE_W-1:0] pc_next_value,
    output types::micro_op_t           uop,
    output logic                       instr_done
);

    types::seq_state            state_q;
    logic [types::OPCODE_W-1:0] opcode_q;
    logic [types::STEP_W-1:0]   step_q;
    logic [types::STEP_W-1:0]   last_step;
    logic                       executing;
    logic                       capture_load;
    logic                       load_pending_q;
    logic [types::OPCODE_W-1:0] load_value_q;

    always_comb begin
        case (dec.length)
            types::CYCLE7:  last_step = 4'd6;
            types::CYCLE12: last_step = 4'd11;
            default:        last_step = 4'd4;
        endcase
    end

    assign executing    = (state_q == types::EXECUTE);
    assign instr_done   = executing && (step_q == last_step);
    assign capture_load = executing && dec.skip_pc_increment && pc_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= types::FETCH;
            step_q  <= '0;
        end else if (!executing) begin
            state_q <= types::EXECUTE;  // Single fetch cycle
            step_q  <= '0;
        end else if (instr_done) begin
            state_q <= types::FETCH;
        end else begin
            step_q <= step_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!executing) begin
            opcode_q <= rom_data;  // Memory answers in the same cycle
        end
    end

    // A skip instruction remembers that the execution unit asked for a jump
    always_ff @(posedge clk) begin
        if (reset || instr_done) begin
            load_pending_q <= 1'b0;
        end else if (capture_load) begin
            load_pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_load) begin
            load_value_q <= pc_load_value;  // Latest target wins
        end
    end

    assign pc_inc        = instr_done && !dec.skip_pc_increment;
    assign pc_load_en    = instr_done && dec.skip_pc_increment && (load_pending_q || pc_load);
    assign pc_next_value = pc_load ? pc_load_value : load_value_q;
    assign opcode        = opcode_q;

    always_comb begin
        uop.start_addr = dec.start_addr;
        uop.step       = step_q;
        uop.immed      = dec.immed;
        uop.first      = executing && (step_q == '0);
    end

endmodule

`default_nettype wire

//--- program_counter.sv
`timescale 1ns/100ps
`default_nettype none

module program_counter (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        inc,
    input  wire                        load_en,
    input  wire  [types::OPCODE_W-1:0] load_value,
    output logic [types::OPCODE_W-1:0] pc
);

    logic [3:0] page_q;  // Selects one 256-word block
    logic [7:0] step_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            page_q <= 4'h0;
            step_q <= 8'h00;
        end else if (load_en) begin
            {page_q, step_q} <= load_value;  // Full jump wins over inc
        end else if (inc) begin
            step_q <= step_q + 8'd1;  // Wraps inside the page
        end
    end

    assign pc = {page_q, step_q};

endmodule

`default_nettype wire

//--- decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode (
    input  wire [types::OPCODE_W-1:0] opcode,
    output types::decode_t            dec
);

    function automatic types::decode_t make_dec(
        input logic [types::UADDR_W-1:0] start_addr,
        input types::instr_length        length,
        input logic                      skip
    );
        types::decode_t d;
        d = '0;
        d.start_addr        = start_addr;
        d.length            = length;
        d.skip_pc_increment = skip;
        return d;
    endfunction

    always_comb begin
        dec = make_dec(7'd0, types::CYCLE5, 1'b0);  // Undefined opcodes
        casez (opcode)
            12'h0??: dec = make_dec(7'd0, types::CYCLE5, 1'b0);   // JP s
            12'h1??: dec = make_dec(7'd1, types::CYCLE12, 1'b1);  // RETD e
            12'h2??: dec = make_dec(7'd2, types::CYCLE5, 1'b0);   // JP C, s
            12'h3??: dec = make_dec(7'd3, types::CYCLE5, 1'b0);   // JP NC, s
            12'h4??: dec = make_dec(7'd4, types::CYCLE7, 1'b1);   // CALL s
            12'h5??: dec = make_dec(7'd5, types::CYCLE7, 1'b1);   // CALZ s
            12'h6??: dec = make_dec(7'd6, types::CYCLE5, 1'b0);   // JP Z, s
            12'h7??: dec = make_dec(7'd7, types::CYCLE5, 1'b0);   // JP NZ, s
            12'h8??: dec = make_dec(7'd8, types::CYCLE5, 1'b0);   // LD Y, e
            12'h9??: dec = make_dec(7'd9, types::CYCLE5, 1'b0);   // LBPX MX, e

            12'hA0?: dec = make_dec(7'd10, types::CYCLE7, 1'b0);  // ADC XH, i
            12'hA1?: dec = make_dec(7'd11, types::CYCLE7, 1'b0);  // ADC XL, i
            12'hA2?: dec = make_dec(7'd12, types::CYCLE7, 1'b0);  // ADC YH, i
            12'hA3?: dec = make_dec(7'd13, types::CYCLE7, 1'b0);  // ADC YL, i
            12'hA4?: dec = make_dec(7'd14, types::CYCLE7, 1'b0);  // CP XH, i
            12'hA5?: dec = make_dec(7'd15, types::CYCLE7, 1'b0);  // CP XL, i
            12'hA6?: dec = make_dec(7'd16, types::CYCLE7, 1'b0);  // CP YH, i
            12'hA7?: dec = make_dec(7'd17, types::CYCLE7, 1'b0);  // CP YL, i
            12'hA8?: dec = make_dec(7'd18, types::CYCLE7, 1'b0);  // ADD r, q
            12'hA9?: dec = make_dec(7'd19, types::CYCLE7, 1'b0);  // ADC r, q
            12'hAA?: dec = make_dec(7'd20, types::CYCLE7, 1'b0);  // SUB r, q
            12'hAB?: dec = make_dec(7'd21, types::CYCLE7, 1'b0);  // SBC r, q
            12'hAC?: dec = make_dec(7'd22, types::CYCLE7, 1'b0);  // AND r, q
            12'hAD?: dec = make_dec(7'd23, types::CYCLE7, 1'b0);  // OR r, q
            12'hAE?: dec = make_dec(7'd24, types::CYCLE7, 1'b0);  // XOR r, q
            12'hAF?: dec = make_dec(7'd25, types::CYCLE7, 1'b0);  // RLC r

            12'hB??: dec = make_dec(7'd26, types::CYCLE5, 1'b0);  // LD X, e

            12'hC??: begin
                case (opcode[7:6])
                    2'b00: dec = make_dec(7'd27, types::CYCLE7, 1'b0);  // ADD r, i
                    2'b01: dec = make_dec(7'd28, types::CYCLE7, 1'b0);  // ADC r, i
                    2'b10: dec = make_dec(7'd29, types::CYCLE7, 1'b0);  // AND r, i
                    2'b11: dec = make_dec(7'd30, types::CYCLE7, 1'b0);  // OR r, i
                endcase
            end
            12'hD??: begin
                case (opcode[7:6])
                    2'b00: dec = make_dec(7'd31, types::CYCLE7, 1'b0);  // XOR r, i
                    2'b01: dec = make_dec(7'd32, types::CYCLE7, 1'b0);  // SBC r, i
                    2'b10: dec = make_dec(7'd33, types::CYCLE7, 1'b0);  // FAN r, i
                    2'b11: dec = make_dec(7'd34, types::CYCLE7, 1'b0);  // CP r, i
                endcase
            end
            12'hE??: begin
                casez (opcode[7:0])  // 9C-9F, AC-AF, BC-BF and Dx are holes
                    8'b00??_????: dec = make_dec(7'd35, types::CYCLE5, 1'b0);  // LD r, i
                    8'b010?_????: dec = make_dec(7'd36, types::CYCLE5, 1'b0);  // PSET p
                    8'b0110_????: dec = make_dec(7'd37, types::CYCLE5, 1'b0);  // LDPX MX, i
                    8'b0111_????: dec = make_dec(7'd38, types::CYCLE5, 1'b0);  // LDPY MY, i
                    8'b1000_00??: dec = make_dec(7'd39, types::CYCLE5, 1'b0);  // LD XP, r
                    8'b1000_01??: dec = make_dec(7'd40, types::CYCLE5, 1'b0);  // LD XH, r
                    8'b1000_10??: dec = make_dec(7'd41, types::CYCLE5, 1'b0);  // LD XL, r
                    8'b1000_11??: dec = make_dec(7'd42, types::CYCLE5, 1'b0);  // RRC r
                    8'b1001_00??: dec = make_dec(7'd43, types::CYCLE5, 1'b0);  // LD YP, r
                    8'b1001_01??: dec = make_dec(7'd44, types::CYCLE5, 1'b0);  // LD YH, r
                    8'b1001_10??: dec = make_dec(7'd45, types::CYCLE5, 1'b0);  // LD YL, r
                    8'b1010_00??: dec = make_dec(7'd46, types::CYCLE5, 1'b0);  // LD r, XP
                    8'b1010_01??: dec = make_dec(7'd47, types::CYCLE5, 1'b0);  // LD r, XH
                    8'b1010_10??: dec = make_dec(7'd48, types::CYCLE5, 1'b0);  // LD r, XL
                    8'b1011_00??: dec = make_dec(7'd49, types::CYCLE5, 1'b0);  // LD r, YP
                    8'b1011_01??: dec = make_dec(7'd50, types::CYCLE5, 1'b0);  // LD r, YH
                    8'b1011_10??: dec = make_dec(7'd51, types::CYCLE5, 1'b0);  // LD r, YL
                    8'b1100_????: dec = make_dec(7'd52, types::CYCLE5, 1'b0);  // LD r, q
                    8'b1110_????: dec = make_dec(7'd53, types::CYCLE5, 1'b0);  // LDPX r, q
                    8'b1111_????: dec = make_dec(7'd54, types::CYCLE5, 1'b0);  // LDPY r, q
                    default: ;
                endcase
            end

            12'hF0?: dec = make_dec(7'd55, types::CYCLE7, 1'b0);  // CP r, q
            12'hF1?: dec = make_dec(7'd56, types::CYCLE7, 1'b0);  // FAN r, q
            12'hF2?: begin
                case (opcode[3:2])
                    2'b10: dec = make_dec(7'd57, types::CYCLE7, 1'b0);  // ACPX MX, r
                    2'b11: dec = make_dec(7'd58, types::CYCLE7, 1'b0);  // ACPY MY, r
                    default: ;
                endcase
            end
            12'hF3?: begin
                case (opcode[3:2])
                    2'b10: dec = make_dec(7'd59, types::CYCLE7, 1'b0);  // SCPX MX, r
                    2'b11: dec = make_dec(7'd60, types::CYCLE7, 1'b0);  // SCPY MY, r
                    default: ;
                endcase
            end
            12'hF4?: dec = make_dec(7'd61, types::CYCLE7, 1'b0);  // SET F, i
            12'hF5?: dec = make_dec(7'd62, types::CYCLE7, 1'b0);  // RST F, i
            12'hF6?: dec = make_dec(7'd63, types::CYCLE7, 1'b0);  // INC Mn
            12'hF7?: dec = make_dec(7'd64, types::CYCLE7, 1'b0);  // DEC Mn
            12'hF8?: dec = make_dec(7'd65, types::CYCLE5, 1'b0);  // LD Mn, A
            12'hF9?: dec = make_dec(7'd66, types::CYCLE5, 1'b0);  // LD Mn, B
            12'hFA?: dec = make_dec(7'd67, types::CYCLE5, 1'b0);  // LD A, Mn
            12'hFB?: dec = make_dec(7'd68, types::CYCLE5, 1'b0);  // LD B, Mn

            12'hFC?: begin
                casez (opcode[3:0])
                    4'b00??: dec = make_dec(7'd69, types::CYCLE5, 1'b0);  // PUSH r
                    4'b0100: dec = make_dec(7'd70, types::CYCLE5, 1'b0);  // PUSH XP
                    4'b0101: dec = make_dec(7'd71, types::CYCLE5, 1'b0);  // PUSH XH
                    4'b0110: dec = make_dec(7'd72, types::CYCLE5, 1'b0);  // PUSH XL
                    4'b0111: dec = make_dec(7'd73, types::CYCLE5, 1'b0);  // PUSH YP
                    4'b1000: dec = make_dec(7'd74, types::CYCLE5, 1'b0);  // PUSH YH
                    4'b1001: dec = make_dec(7'd75, types::CYCLE5, 1'b0);  // PUSH YL
                    4'b1010: dec = make_dec(7'd76, types::CYCLE5, 1'b0);  // PUSH F
                    4'b1011: dec = make_dec(7'd77, types::CYCLE5, 1'b0);  // DEC SP
                    default: ;
                endcase
            end
            12'hFD?: begin
                casez (opcode[3:0])
                    4'b00??: dec = make_dec(7'd78, types::CYCLE5, 1'b0);   // POP r
                    4'b0100: dec = make_dec(7'd79, types::CYCLE5, 1'b0);   // POP XP
                    4'b0101: dec = make_dec(7'd80, types::CYCLE5, 1'b0);   // POP XH
                    4'b0110: dec = make_dec(7'd81, types::CYCLE5, 1'b0);   // POP XL
                    4'b0111: dec = make_dec(7'd82, types::CYCLE5, 1'b0);   // POP YP
                    4'b1000: dec = make_dec(7'd83, types::CYCLE5, 1'b0);   // POP YH
                    4'b1001: dec = make_dec(7'd84, types::CYCLE5, 1'b0);   // POP YL
                    4'b1010: dec = make_dec(7'd85, types::CYCLE5, 1'b0);   // POP F
                    4'b1011: dec = make_dec(7'd86, types::CYCLE5, 1'b0);   // INC SP
                    4'b1110: dec = make_dec(7'd87, types::CYCLE12, 1'b0);  // RETS
                    4'b1111: dec = make_dec(7'd88, types::CYCLE7, 1'b1);   // RET
                    default: ;
                endcase
            end
            12'hFE?: begin
                casez (opcode[3:0])
                    4'b00??: dec = make_dec(7'd89, types::CYCLE5, 1'b0);  // LD SPH, r
                    4'b01??: dec = make_dec(7'd90, types::CYCLE5, 1'b0);  // LD r, SPH
                    4'b1000: dec = make_dec(7'd91, types::CYCLE5, 1'b0);  // JPBA
                    default: ;
                endcase
            end
            12'hFF?: begin
                casez (opcode[3:0])
                    4'b00??: dec = make_dec(7'd92, types::CYCLE5, 1'b0);  // LD SPL, r
                    4'b01??: dec = make_dec(7'd93, types::CYCLE5, 1'b0);  // LD r, SPL
                    4'b1000: dec = make_dec(7'd94, types::CYCLE5, 1'b0);  // HALT
                    4'b1001: dec = make_dec(7'd95, types::CYCLE5, 1'b0);  // SLP
                    4'b1011: dec = make_dec(7'd96, types::CYCLE5, 1'b0);  // NOP5
                    4'b1111: dec = make_dec(7'd97, types::CYCLE7, 1'b0);  // NOP7
                    default: ;
                endcase
            end
            default: ;
        endcase
        dec.immed = opcode[7:0];  // Low byte is always the operand field
    end

endmodule

`default_nettype wire

//--- types.sv
`default_nettype none

package types;

    localparam int OPCODE_W = 12;  // Also the program address width
    localparam int UADDR_W  = 7;
    localparam int STEP_W   = 4;
    localparam int IMMED_W  = 8;

    typedef enum logic [1:0] {
        CYCLE5,
        CYCLE7,
        CYCLE12
    } instr_length;

    typedef enum logic {
        FETCH,
        EXECUTE
    } seq_state;

    typedef struct packed {
        logic [UADDR_W-1:0] start_addr;
        instr_length        length;
        logic [IMMED_W-1:0] immed;
        logic               skip_pc_increment;  // Execution unit owns the PC
    } decode_t;

    // Per-cycle command to the microcode engine
    typedef struct packed {
        logic [UADDR_W-1:0] start_addr;
        logic [STEP_W-1:0]  step;
        logic [IMMED_W-1:0] immed;
        logic               first;
    } micro_op_t;

endpackage

`default_nettype wire
